/* vita_tx_settings.svh */
`ifndef VITA_TX_SETTINGS_SVH
`define VITA_TX_SETTINGS_SVH

// Sample word width
`define VTX_SAMPLE_W 32

// Power of two, at least 4
`define VTX_FIFO_DEPTH 64

// Settings bus addresses
`define VTX_ADDR_TIME_HI 8'd0
`define VTX_ADDR_TIME_LO 8'd1
`define VTX_ADDR_CLEAR   8'd2

`endif

/* vita_tx_pkg.sv */
`include "vita_tx_settings.svh"

package vita_tx_pkg;

   // Packet header word
   typedef struct packed {
      logic        sob;
      logic        eob;
      logic        send_at;   // Two time words follow
      logic [3:0]  seqnum;
      logic [12:0] spare;
      logic [11:0] len;       // Payload length in samples
   } vtx_hdr_t;

   // Header view or raw view of one input word
   typedef union packed {
      vtx_hdr_t    hdr;
      logic [31:0] raw;
   } vtx_word_u;

   // One sample as stored in the sample FIFO
   typedef struct packed {
      logic [`VTX_SAMPLE_W-1:0] sample;
      logic [63:0]              send_time;
      logic                     eop;
      logic                     eob;
      logic                     sob;
      logic                     send_at;
      logic                     seqnum_err;
   } vtx_entry_t;

   typedef enum logic [15:0] {
      ERR_NONE               = 16'd0,
      ERR_UNDERRUN           = 16'd2,
      ERR_SEQ_ERROR          = 16'd4,
      ERR_TIME_ERROR         = 16'd8,
      ERR_UNDERRUN_MIDPKT    = 16'd16,
      ERR_SEQ_ERROR_MIDBURST = 16'd32
   } vtx_err_code_t;

endpackage

/* vita_timer.sv */
`include "vita_tx_settings.svh"

module vita_timer (
   input  logic        clk,
   input  logic        reset_i,
   input  logic        set_stb_i,
   input  logic [7:0]  set_addr_i,
   input  logic [31:0] set_data_i,
   output logic [63:0] vita_time_o
);

   logic [31:0] time_hi_q;   // Pending upper half
   logic        load_hi;
   logic        load_lo;

   assign load_hi = set_stb_i && (set_addr_i == `VTX_ADDR_TIME_HI);
   assign load_lo = set_stb_i && (set_addr_i == `VTX_ADDR_TIME_LO);

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         time_hi_q   <= '0;
         vita_time_o <= '0;
      end
      else
      begin
         if (load_hi)
            time_hi_q <= set_data_i;
         if (load_lo)
            vita_time_o <= {time_hi_q, set_data_i};   // Both halves at once
         else
            vita_time_o <= vita_time_o + 64'd1;
      end
   end

endmodule

/* vita_tx_deframer.sv */
module vita_tx_deframer (
   input  logic                    clk,
   input  logic                    reset_i,
   input  logic                    clear_i,
   input  vita_tx_pkg::vtx_word_u  word_i,
   input  logic                    word_valid_i,
   output logic                    word_ready_o,
   output logic                    push_o,
   output vita_tx_pkg::vtx_entry_t entry_o,
   input  logic                    full_i
);

   typedef enum logic [1:0] {
      S_HDR,
      S_TIME_HI,
      S_TIME_LO,
      S_PAYLOAD
   } state_t;

   state_t                  state_q;
   logic                    xfer;
   logic [11:0]             remain_q;     // Payload words still to come
   logic [3:0]              exp_seq_q;
   logic                    seq_valid_q;  // A previous header was seen
   logic                    seq_err;
   logic                    seq_err_q;
   vita_tx_pkg::vtx_hdr_t   hdr_q;
   logic [63:0]             send_time_q;

   // Only payload words wait for FIFO space
   assign word_ready_o = (state_q != S_PAYLOAD) || !full_i;
   assign xfer         = word_valid_i && word_ready_o;
   assign seq_err      = seq_valid_q && (word_i.hdr.seqnum != exp_seq_q);

   always_ff @(posedge clk)
   begin
      if (reset_i || clear_i)
      begin
         state_q     <= S_HDR;
         remain_q    <= '0;
         exp_seq_q   <= '0;
         seq_valid_q <= 1'b0;
         push_o      <= 1'b0;
      end
      else
      begin
         push_o <= 1'b0;
         if (xfer)
         begin
            case (state_q)
               S_HDR:
               begin
                  seq_valid_q <= 1'b1;
                  exp_seq_q   <= word_i.hdr.seqnum + 4'd1;
                  remain_q    <= word_i.hdr.len;
                  if (word_i.hdr.len == '0)
                     state_q <= S_HDR;   // Empty packet dropped
                  else if (word_i.hdr.send_at)
                     state_q <= S_TIME_HI;
                  else
                     state_q <= S_PAYLOAD;
               end
               S_TIME_HI:
                  state_q <= S_TIME_LO;
               S_TIME_LO:
                  state_q <= S_PAYLOAD;
               S_PAYLOAD:
               begin
                  push_o   <= 1'b1;
                  remain_q <= remain_q - 12'd1;
                  if (remain_q == 12'd1)
                     state_q <= S_HDR;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (xfer)
      begin
         case (state_q)
            S_HDR:
            begin
               hdr_q       <= word_i.hdr;
               seq_err_q   <= seq_err;
               send_time_q <= '0;
            end
            S_TIME_HI:
               send_time_q[63:32] <= word_i.raw;
            S_TIME_LO:
               send_time_q[31:0] <= word_i.raw;
            S_PAYLOAD:
               entry_o <= '{sample:     word_i.raw,
                            send_time:  send_time_q,
                            eop:        (remain_q == 12'd1),
                            eob:        hdr_q.eob,
                            sob:        hdr_q.sob,
                            send_at:    hdr_q.send_at,
                            seqnum_err: seq_err_q};
         endcase
      end
   end

endmodule

/* sample_fifo.sv */
`include "vita_tx_settings.svh"

module sample_fifo (
   input  logic                    clk,
   input  logic                    reset_i,
   input  logic                    push_i,
   input  vita_tx_pkg::vtx_entry_t entry_i,
   input  logic                    pop_i,
   output vita_tx_pkg::vtx_entry_t head_o,
   output logic                    not_empty_o,
   output logic                    full_o
);

   localparam int          DEPTH   = `VTX_FIFO_DEPTH;
   localparam int          AW      = $clog2(DEPTH);
   localparam logic [AW:0] DEPTH_C = (AW+1)'(DEPTH);

   vita_tx_pkg::vtx_entry_t mem [DEPTH];
   logic [AW-1:0]           wr_ptr_q;
   logic [AW-1:0]           rd_ptr_q;
   logic [AW:0]             count_q;
   logic                    do_push;
   logic                    do_pop;

   assign do_push     = push_i && (count_q != DEPTH_C);
   assign do_pop      = pop_i && not_empty_o;
   assign not_empty_o = (count_q != '0);
   assign head_o      = mem[rd_ptr_q];

   // Also counts the entry in flight from the deframer register
   assign full_o = (count_q == DEPTH_C) ||
                   (push_i && (count_q == DEPTH_C - (AW+1)'(1)));

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr_q] <= entry_i;
   end

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + AW'(1);
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + AW'(1);
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + (AW+1)'(1);
            2'b01:   count_q <= count_q - (AW+1)'(1);
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

/* vita_tx_control.sv */
`include "vita_tx_settings.svh"

module vita_tx_control (
   input  logic                       clk,
   input  logic                       reset_i,
   input  logic                       set_stb_i,
   input  logic [7:0]                 set_addr_i,
   input  logic [31:0]                set_data_i,
   input  logic [63:0]                vita_time_i,
   input  vita_tx_pkg::vtx_entry_t    head_i,
   input  logic                       not_empty_i,
   output logic                       pop_o,
   input  logic                       strobe_i,
   output logic [`VTX_SAMPLE_W-1:0]   sample_o,
   output logic                       run_o,
   output logic                       error_o,
   output vita_tx_pkg::vtx_err_code_t error_code_o,
   output logic                       clear_o
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_RUN,
      ST_CONT_BURST,   // Between packets of one burst
      ST_ERROR,        // Draining the rest of the bad packet
      ST_ERROR_DONE
   } state_t;

   state_t state_q;
   logic   now;
   logic   late;

   assign now  = (vita_time_i == head_i.send_time);
   assign late = (vita_time_i > head_i.send_time);

   // Pulse on any write to the clear address
   always_ff @(posedge clk)
   begin
      if (reset_i)
         clear_o <= 1'b0;
      else
         clear_o <= set_stb_i && (set_addr_i == `VTX_ADDR_CLEAR);
   end

   always_ff @(posedge clk)
   begin
      if (reset_i || clear_o)
      begin
         state_q      <= ST_IDLE;
         error_code_o <= vita_tx_pkg::ERR_NONE;
      end
      else
      begin
         case (state_q)
            ST_IDLE:
               if (not_empty_i)
               begin
                  if (head_i.seqnum_err)
                  begin
                     state_q      <= ST_ERROR;
                     error_code_o <= vita_tx_pkg::ERR_SEQ_ERROR;
                  end
                  else if (!head_i.send_at || now)
                     state_q <= ST_RUN;
                  else if (late)
                  begin
                     state_q      <= ST_ERROR;
                     error_code_o <= vita_tx_pkg::ERR_TIME_ERROR;
                  end
               end
            ST_RUN:
               if (strobe_i)
               begin
                  if (!not_empty_i)
                  begin
                     state_q      <= ST_ERROR;
                     error_code_o <= vita_tx_pkg::ERR_UNDERRUN_MIDPKT;
                  end
                  else if (head_i.eop)
                     state_q <= head_i.eob ? ST_IDLE : ST_CONT_BURST;
               end
            ST_CONT_BURST:
               if (strobe_i)
               begin
                  state_q      <= ST_ERROR_DONE;   // Next packet not there in time
                  error_code_o <= vita_tx_pkg::ERR_UNDERRUN;
               end
               else if (not_empty_i)
               begin
                  if (head_i.seqnum_err)
                  begin
                     state_q      <= ST_ERROR;
                     error_code_o <= vita_tx_pkg::ERR_SEQ_ERROR_MIDBURST;
                  end
                  else
                     state_q <= ST_RUN;
               end
            ST_ERROR:
               if (not_empty_i && head_i.eop)
                  state_q <= ST_ERROR_DONE;
            ST_ERROR_DONE:
               state_q <= ST_ERROR_DONE;   // Until clear
            default:
               state_q <= ST_IDLE;
         endcase
      end
   end

   assign pop_o    = ((state_q == ST_ERROR) && not_empty_i) ||
                     ((state_q == ST_RUN) && strobe_i);
   assign sample_o = head_i.sample;
   assign run_o    = (state_q == ST_RUN) || (state_q == ST_CONT_BURST);
   assign error_o  = (state_q == ST_ERROR_DONE);

endmodule

/* vita_tx_core.sv */
`include "vita_tx_settings.svh"

module vita_tx_core (
   input  logic                       clk,
   input  logic                       reset_i,
   input  logic                       set_stb_i,
   input  logic [7:0]                 set_addr_i,
   input  logic [31:0]                set_data_i,
   input  vita_tx_pkg::vtx_word_u     word_i,
   input  logic                       word_valid_i,
   output logic                       word_ready_o,
   input  logic                       strobe_i,
   output logic [`VTX_SAMPLE_W-1:0]   sample_o,
   output logic                       run_o,
   output logic                       error_o,
   output vita_tx_pkg::vtx_err_code_t error_code_o
);

   logic [63:0]             vita_time;
   logic                    clear;
   logic                    push;
   logic                    pop;
   logic                    not_empty;
   logic                    full;
   vita_tx_pkg::vtx_entry_t entry;
   vita_tx_pkg::vtx_entry_t head;

   vita_timer i_timer (
      .clk         (clk),
      .reset_i     (reset_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .vita_time_o (vita_time)
   );

   vita_tx_deframer i_deframer (
      .clk          (clk),
      .reset_i      (reset_i),
      .clear_i      (clear),
      .word_i       (word_i),
      .word_valid_i (word_valid_i),
      .word_ready_o (word_ready_o),
      .push_o       (push),
      .entry_o      (entry),
      .full_i       (full)
   );

   sample_fifo i_fifo (
      .clk         (clk),
      .reset_i     (reset_i),
      .push_i      (push),
      .entry_i     (entry),
      .pop_i       (pop),
      .head_o      (head),
      .not_empty_o (not_empty),
      .full_o      (full)
   );

   vita_tx_control i_control (
      .clk          (clk),
      .reset_i      (reset_i),
      .set_stb_i    (set_stb_i),
      .set_addr_i   (set_addr_i),
      .set_data_i   (set_data_i),
      .vita_time_i  (vita_time),
      .head_i       (head),
      .not_empty_i  (not_empty),
      .pop_o        (pop),
      .strobe_i     (strobe_i),
      .sample_o     (sample_o),
      .run_o        (run_o),
      .error_o      (error_o),
      .error_code_o (error_code_o),
      .clear_o      (clear)
   );

endmodule

/* vita_tx_checker.sv */
module vita_tx_checker (
   input  logic                       clk,
   input  logic                       reset_i,
   input  logic                       error_i,
   input  logic                       push_i,
   input  logic                       fifo_push_i,
   input  logic [2:0]                 ctrl_state_i,
   input  vita_tx_pkg::vtx_err_code_t error_code_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // Error states always carry a code
   assert property (@(posedge clk) disable iff (reset_i)
                    (error_i || (ctrl_state_i == 3'd3)) |->
                    (error_code_i != vita_tx_pkg::ERR_NONE))
      else $error("error state without error code");

   // Back-pressure stops words before the FIFO overflows
   assert property (@(posedge clk) disable iff (reset_i) push_i |-> fifo_push_i)
      else $error("deframer entry dropped by full FIFO");

   assert property (@(posedge clk) disable iff (reset_i)
                    error_i || (ctrl_state_i == 3'd3) ||
                    (error_code_i == vita_tx_pkg::ERR_NONE))
      else $error("error_code_o set outside error states");

endmodule

bind vita_tx_core vita_tx_checker i_checker (
   .clk          (clk),
   .reset_i      (reset_i),
   .error_i      (error_o),
   .push_i       (push),
   .fifo_push_i  (i_fifo.do_push),
   .ctrl_state_i (i_control.state_q),
   .error_code_i (error_code_o)
);

/* tb_vita_tx.sv */
`include "vita_tx_settings.svh"

module tb_vita_tx;

   timeunit 1ns;
   timeprecision 100ps;

   logic                       clk;
   logic                       reset_i;
   logic                       set_stb_i;
   logic [7:0]                 set_addr_i;
   logic [31:0]                set_data_i;
   vita_tx_pkg::vtx_word_u     word_i;
   logic                       word_valid_i;
   logic                       word_ready_o;
   logic                       strobe_i;
   logic [`VTX_SAMPLE_W-1:0]   sample_o;
   logic                       run_o;
   logic                       error_o;
   vita_tx_pkg::vtx_err_code_t error_code_o;

   logic [15:0] lfsr = 16'd39258;
   logic [31:0] model_hi;
   logic [63:0] model_time;    // Mirrors the DUT time counter
   logic [3:0]  seq = 4'd0;
   logic [31:0] exp_q[$];      // Expected samples in order
   int          words_sent = 0;
   int          cycle_cnt = 0;

   vita_tx_core i_vita_tx_core (.*);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (reset_i)
         model_time <= 64'd0;
      else if (set_stb_i && (set_addr_i == `VTX_ADDR_TIME_LO))
         model_time <= {model_hi, set_data_i};
      else
         model_time <= model_time + 64'd1;
      if (set_stb_i && (set_addr_i == `VTX_ADDR_TIME_HI))
         model_hi <= set_data_i;
   end

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic abort_run();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic set_write(input logic [7:0] addr, input logic [31:0] data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      next_cycle();
      set_stb_i = 1'b0;
   endtask

   task automatic send_word(input logic [31:0] w);
      if (rand_bits(2) == 32'd0)
         next_cycle();   // Random valid gap
      word_i.raw   = w;
      word_valid_i = 1'b1;
      // Bursts never fill the FIFO so every word goes in at once
      check("word_ready_o", 64'(word_ready_o), 64'd1);
      next_cycle();
      word_valid_i = 1'b0;
      words_sent++;
   endtask

   task automatic send_header(input logic sob, input logic eob, input logic send_at,
                              input int len, input logic [63:0] t);
      vita_tx_pkg::vtx_word_u w;
      w.hdr = '{sob: sob, eob: eob, send_at: send_at, seqnum: seq, spare: '0,
                len: 12'(len)};
      seq = seq + 4'd1;
      send_word(w.raw);
      if (send_at)
      begin
         send_word(t[63:32]);
         send_word(t[31:0]);
      end
   endtask

   task automatic send_payload(input int n, input logic keep);
      logic [31:0] s;
      for (int i = 0; i < n; i++)
      begin
         s = rand_bits(32);
         if (keep)
            exp_q.push_back(s);
         send_word(s);
      end
   endtask

   task automatic send_packet(input logic sob, input logic eob, input logic send_at,
                              input int len, input logic [63:0] t, input logic keep);
      send_header(sob, eob, send_at, len, t);
      send_payload(len, keep);
   endtask

   // One DSP strobe pulse every 4 cycles
   task automatic strobe_once(output logic run, output logic [31:0] smp);
      strobe_i = 1'b1;
      run      = run_o;
      smp      = sample_o;
      next_cycle();
      strobe_i = 1'b0;
      repeat (3) next_cycle();
   endtask

   task automatic drain();
      logic        r;
      logic [31:0] s;
      repeat (3) next_cycle();
      while (exp_q.size() != 0)
      begin
         strobe_once(r, s);
         check("run_o", 64'(r), 64'd1);
         check("sample_o", 64'(s), 64'(exp_q.pop_front()));
      end
   endtask

   task automatic wait_error(input logic [15:0] code);
      int n;
      n = 0;
      while (!error_o && (n < 200))
      begin
         next_cycle();
         n++;
      end
      if (!error_o)
      begin
         $display("error_o did not rise within 200 cycles");
         abort_run();
      end
      check("error_code_o", 64'(error_code_o), 64'(code));
   endtask

   task automatic clear_error();
      set_write(`VTX_ADDR_CLEAR, 32'd0);
      repeat (2) next_cycle();
      check("error_o", 64'(error_o), 64'd0);
      check("error_code_o", 64'(error_code_o), 64'd0);
   endtask

   task automatic run_burst();
      int npkt;
      npkt = 1 + int'(rand_bits(2) % 32'd3);
      for (int p = 0; p < npkt; p++)
         send_packet(p == 0, p == npkt - 1, 1'b0, 1 + int'(rand_bits(4) % 32'd12),
                     64'd0, 1'b1);
      drain();
      repeat (2) next_cycle();
      check("run_o", 64'(run_o), 64'd0);
      check("error_o", 64'(error_o), 64'd0);
   endtask

   initial
   begin
      while (cycle_cnt <= 40 * words_sent + 2000)
         @(posedge clk);
      $display("Watchdog timeout, DUT stopped making progress");
      abort_run();
   end

   initial
   begin
      logic [63:0] t;
      logic        r;
      logic [31:0] s;
      int          n;
      reset_i      = 1'b1;
      set_stb_i    = 1'b0;
      set_addr_i   = '0;
      set_data_i   = '0;
      word_i       = '0;
      word_valid_i = 1'b0;
      strobe_i     = 1'b0;
      repeat (4) @(posedge clk);
      #1 reset_i = 1'b0;
      next_cycle();

      repeat (6) run_burst();

      // Timed release
      set_write(`VTX_ADDR_TIME_HI, rand_bits(31));
      set_write(`VTX_ADDR_TIME_LO, rand_bits(32));
      next_cycle();
      t = model_time + 64'(50 + int'(rand_bits(7)));
      send_packet(1'b1, 1'b1, 1'b1, 1 + int'(rand_bits(4) % 32'd12), t, 1'b1);
      while (model_time <= t)
      begin
         check("run_o", 64'(run_o), 64'd0);
         next_cycle();
      end
      n = 0;
      while (!run_o && (n < 2))
      begin
         next_cycle();
         n++;
      end
      check("run_o", 64'(run_o), 64'd1);
      drain();

      // Late packet
      send_packet(1'b1, 1'b1, 1'b1, 4, model_time - 64'd10, 1'b0);
      wait_error(16'd8);
      clear_error();
      run_burst();

      // Gap inside a burst, then gap on a first packet
      send_packet(1'b1, 1'b0, 1'b0, 1 + int'(rand_bits(4) % 32'd12), 64'd0, 1'b1);
      seq = seq + 4'd1;
      send_packet(1'b0, 1'b1, 1'b0, 5, 64'd0, 1'b0);
      drain();
      wait_error(16'd32);
      clear_error();
      send_packet(1'b1, 1'b1, 1'b0, 3, 64'd0, 1'b1);
      drain();
      seq = seq + 4'd1;
      send_packet(1'b1, 1'b1, 1'b0, 3, 64'd0, 1'b0);
      wait_error(16'd4);
      clear_error();

      // Burst ends without eob
      send_packet(1'b1, 1'b0, 1'b0, 1 + int'(rand_bits(4) % 32'd12), 64'd0, 1'b1);
      drain();
      strobe_once(r, s);
      check("run_o", 64'(r), 64'd1);
      wait_error(16'd2);
      clear_error();

      // Underrun inside a packet
      n = 3 + int'(rand_bits(4) % 32'd10);
      send_header(1'b1, 1'b1, 1'b0, n, 64'd0);
      send_payload(n - 2, 1'b1);
      drain();
      strobe_once(r, s);
      check("run_o", 64'(r), 64'd1);
      send_payload(2, 1'b0);
      wait_error(16'd16);
      clear_error();
      run_burst();

      $display("Test passed");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+.
vita_tx_pkg.sv
vita_timer.sv
vita_tx_deframer.sv
sample_fifo.sv
vita_tx_control.sv
vita_tx_core.sv
vita_tx_checker.sv
tb_vita_tx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_vita_tx -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Build error"
   exit 1
fi

./obj_dir/Vtb_vita_tx > sim.log 2>&1
rc=$?
cat sim.log

if grep -q "Test failed" sim.log; then
   exit 1
fi
if [ $rc -ne 0 ]; then
   echo "Simulation exited with status $rc"
   exit 1
fi
exit 0
